//--- cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] word_t;   // bus, registers and memory data
    typedef logic [63:0] dword_t;  // full ALU result held in Z
    typedef logic [4:0]  opcode_t;

    // ALU operation codes
    localparam opcode_t opAdd  = 5'b00011;
    localparam opcode_t opSub  = 5'b00100;
    localparam opcode_t opAnd  = 5'b00101;
    localparam opcode_t opOr   = 5'b00110;
    localparam opcode_t opShr  = 5'b00111;
    localparam opcode_t opShra = 5'b01000;
    localparam opcode_t opShl  = 5'b01001;
    localparam opcode_t opRor  = 5'b01010;
    localparam opcode_t opRol  = 5'b01011;
    localparam opcode_t opMul  = 5'b01111;
    localparam opcode_t opDiv  = 5'b10000;
    localparam opcode_t opNeg  = 5'b10001;
    localparam opcode_t opNot  = 5'b10010;

endpackage

//--- registerFile.sv
`timescale 1ns/1ps

module registerFile #(
    parameter int numRegs = 16
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  cpuPkg::word_t        bus,
    input  logic [numRegs-1:0]   regEnable,
    input  logic [numRegs-1:0]   regOut,
    output cpuPkg::word_t        regBusValue
);
    import cpuPkg::*;

    word_t regs [numRegs];

    // each register loads the bus on its own enable
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numRegs; i++) begin
                if (regEnable[i]) begin
                    regs[i] <= bus;
                end
            end
        end
    end

    // and-or read path, zero when no select is set
    always_comb begin
        regBusValue = '0;
        for (int i = 0; i < numRegs; i++) begin
            if (regOut[i]) begin
                regBusValue = regBusValue | regs[i];
            end
        end
    end

endmodule

//--- specialRegs.sv
`timescale 1ns/1ps

module specialRegs (
    input  logic          Clock,
    input  logic          rstN,
    input  cpuPkg::word_t bus,
    input  logic          pcEnable,
    input  logic          incPc,
    input  logic          irEnable,
    input  logic          hiEnable,
    input  logic          loEnable,
    output cpuPkg::word_t pcValue,
    output cpuPkg::word_t irValue,
    output cpuPkg::word_t hiValue,
    output cpuPkg::word_t loValue
);
    import cpuPkg::*;

    word_t pcNext;

    assign pcNext = incPc ? pcValue + word_t'(1) : bus; // increment or jump target

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pcValue <= '0;
        end else if (pcEnable) begin
            pcValue <= pcNext;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            irValue <= '0;
            hiValue <= '0;
            loValue <= '0;
        end else begin
            if (irEnable) begin
                irValue <= bus; // held for the decoder
            end
            if (hiEnable) begin
                hiValue <= bus;
            end
            if (loEnable) begin
                loValue <= bus;
            end
        end
    end

endmodule

//--- memPort.sv
`timescale 1ns/1ps

module memPort (
    input  logic          Clock,
    input  logic          rstN,
    input  cpuPkg::word_t bus,
    input  cpuPkg::word_t mdatain,
    input  logic          read,
    input  logic          mdrEnable,
    input  logic          marEnable,
    output cpuPkg::word_t mdrValue,
    output cpuPkg::word_t marValue
);
    import cpuPkg::*;

    word_t mdrIn;

    assign mdrIn = read ? mdatain : bus; // memory data during a read cycle

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            mdrValue <= '0;
        end else if (mdrEnable) begin
            mdrValue <= mdrIn;
        end
    end

    // address register, seen by memory directly
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            marValue <= '0;
        end else if (marEnable) begin
            marValue <= bus;
        end
    end

endmodule

//--- aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic            Clock,
    input  logic            rstN,
    input  cpuPkg::word_t   bus,
    input  logic            yEnable,
    input  logic            zEnable,
    input  cpuPkg::opcode_t opcode,
    output cpuPkg::word_t   zLowValue,
    output cpuPkg::word_t   zHighValue
);
    import cpuPkg::*;

    word_t              y;
    dword_t             z;
    dword_t             result;
    logic [4:0]         shAmt;
    logic [63:0]        rorWide;
    logic [63:0]        rolWide;
    dword_t             product;
    logic signed [31:0] ySigned;
    logic signed [31:0] bSigned;
    word_t              quotient;
    word_t              remainder;

    assign shAmt   = bus[4:0]; // count from low five bits
    assign rorWide = {y, y} >> shAmt;
    assign rolWide = {y, y} << shAmt;
    assign ySigned = y;
    assign bSigned = bus;

    // sign-extended operands give the signed 64-bit product
    assign product = {{32{y[31]}}, y} * {{32{bus[31]}}, bus};

    always_comb begin
        if (bus == '0) begin
            quotient  = '1;
            remainder = y;
        end else begin
            quotient  = word_t'(ySigned / bSigned);
            remainder = word_t'(ySigned % bSigned);
        end
    end

    always_comb begin
        result = '0;
        case (opcode)
            opAdd:   result = {32'h0, y + bus};
            opSub:   result = {32'h0, y - bus};
            opAnd:   result = {32'h0, y & bus};
            opOr:    result = {32'h0, y | bus};
            opShr:   result = {32'h0, y >> shAmt};
            opShra:  result = {32'h0, word_t'(ySigned >>> shAmt)};
            opShl:   result = {32'h0, y << shAmt};
            opRor:   result = {32'h0, rorWide[31:0]};
            opRol:   result = {32'h0, rolWide[63:32]};
            opMul:   result = product;
            opDiv:   result = {remainder, quotient};
            opNeg:   result = {32'h0, -bus}; // unary ops take the bus only
            opNot:   result = {32'h0, ~bus};
            default: result = '0;
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            y <= '0;
            z <= '0;
        end else begin
            if (yEnable) begin
                y <= bus;
            end
            if (zEnable) begin
                z <= result;
            end
        end
    end

    assign zLowValue  = z[31:0];
    assign zHighValue = z[63:32];

endmodule

//--- busMux.sv
`timescale 1ns/1ps

module busMux (
    input  cpuPkg::word_t regBusValue,
    input  logic          regSel,
    input  logic          pcOut,
    input  logic          zLowOut,
    input  logic          zHighOut,
    input  logic          hiOut,
    input  logic          loOut,
    input  logic          mdrOut,
    input  cpuPkg::word_t pcValue,
    input  cpuPkg::word_t zLowValue,
    input  cpuPkg::word_t zHighValue,
    input  cpuPkg::word_t hiValue,
    input  cpuPkg::word_t loValue,
    input  cpuPkg::word_t mdrValue,
    output cpuPkg::word_t bus
);
    import cpuPkg::*;

    localparam int wordBits = $bits(word_t);

    word_t regTerm;
    word_t pcTerm;
    word_t zLowTerm;
    word_t zHighTerm;
    word_t hiTerm;
    word_t loTerm;
    word_t mdrTerm;

    // each source is masked by its own select
    assign regTerm   = {wordBits{regSel}}   & regBusValue;
    assign pcTerm    = {wordBits{pcOut}}    & pcValue;
    assign zLowTerm  = {wordBits{zLowOut}}  & zLowValue;
    assign zHighTerm = {wordBits{zHighOut}} & zHighValue;
    assign hiTerm    = {wordBits{hiOut}}    & hiValue;
    assign loTerm    = {wordBits{loOut}}    & loValue;
    assign mdrTerm   = {wordBits{mdrOut}}   & mdrValue;

    // all-zero selects leave the bus at zero
    assign bus = regTerm | pcTerm | zLowTerm | zHighTerm | hiTerm | loTerm | mdrTerm;

endmodule

//--- datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter int numRegs = 16
) (
    input  logic               Clock,
    input  logic               rstN,
    input  logic [numRegs-1:0] regEnable,
    input  logic [numRegs-1:0] regOut,
    input  logic               pcOut,
    input  logic               zLowOut,
    input  logic               zHighOut,
    input  logic               hiOut,
    input  logic               loOut,
    input  logic               mdrOut,
    input  logic               marEnable,
    input  logic               mdrEnable,
    input  logic               irEnable,
    input  logic               yEnable,
    input  logic               zEnable,
    input  logic               pcEnable,
    input  logic               hiEnable,
    input  logic               loEnable,
    input  logic               incPc,
    input  logic               read,
    input  cpuPkg::opcode_t    opcode,
    input  cpuPkg::word_t      mdatain,
    output cpuPkg::word_t      bus,
    output cpuPkg::word_t      marValue,
    output cpuPkg::word_t      irValue
);
    import cpuPkg::*;

    word_t regBusValue;
    word_t pcValue;
    word_t hiValue;
    word_t loValue;
    word_t mdrValue;
    word_t zLowValue;
    word_t zHighValue;
    logic  regSel;

    assign regSel = |regOut; // any general register on the bus

    registerFile #(
        .numRegs(numRegs)
    ) i_registerFile (
        .Clock(Clock),
        .rstN(rstN),
        .bus(bus),
        .regEnable(regEnable),
        .regOut(regOut),
        .regBusValue(regBusValue)
    );

    specialRegs i_specialRegs (
        .Clock(Clock),
        .rstN(rstN),
        .bus(bus),
        .pcEnable(pcEnable),
        .incPc(incPc),
        .irEnable(irEnable),
        .hiEnable(hiEnable),
        .loEnable(loEnable),
        .pcValue(pcValue),
        .irValue(irValue),
        .hiValue(hiValue),
        .loValue(loValue)
    );

    memPort i_memPort (
        .Clock(Clock),
        .rstN(rstN),
        .bus(bus),
        .mdatain(mdatain),
        .read(read),
        .mdrEnable(mdrEnable),
        .marEnable(marEnable),
        .mdrValue(mdrValue),
        .marValue(marValue)
    );

    aluUnit i_aluUnit (
        .Clock(Clock),
        .rstN(rstN),
        .bus(bus),
        .yEnable(yEnable),
        .zEnable(zEnable),
        .opcode(opcode),
        .zLowValue(zLowValue),
        .zHighValue(zHighValue)
    );

    busMux i_busMux (
        .regBusValue(regBusValue),
        .regSel(regSel),
        .pcOut(pcOut),
        .zLowOut(zLowOut),
        .zHighOut(zHighOut),
        .hiOut(hiOut),
        .loOut(loOut),
        .mdrOut(mdrOut),
        .pcValue(pcValue),
        .zLowValue(zLowValue),
        .zHighValue(zHighValue),
        .hiValue(hiValue),
        .loValue(loValue),
        .mdrValue(mdrValue),
        .bus(bus)
    );

endmodule

//--- datapath_asserts.sv
`timescale 1ns/1ps

module datapath_asserts #(
    parameter int numRegs = 16
) (
    input logic               Clock,
    input logic               rstN,
    input logic [numRegs-1:0] regEnable,
    input logic [numRegs-1:0] regOut,
    input logic               pcOut, zLowOut, zHighOut, hiOut, loOut, mdrOut,
    input logic               marEnable, mdrEnable, irEnable, yEnable,
    input logic               zEnable, pcEnable, hiEnable, loEnable,
    input logic               read
);
    logic [numRegs+5:0] busSel;
    logic               anyLoad;

    assign busSel  = {regOut, pcOut, zLowOut, zHighOut, hiOut, loOut, mdrOut};
    assign anyLoad = (|regEnable) | marEnable | mdrEnable | irEnable | yEnable
                   | zEnable | pcEnable | hiEnable | loEnable;

    busOneDriver: assert property (@(posedge Clock) disable iff (!rstN) $onehot0(busSel))
        else $error("more than one source selected onto the bus");

    readLoadsMdr: assert property (@(posedge Clock) disable iff (!rstN) read |-> mdrEnable)
        else $error("read strobe given without an MDR load");

    quietInReset: assert property (@(posedge Clock) !rstN |-> !anyLoad)
        else $error("register load strobe active during reset");

endmodule

bind datapath datapath_asserts #(.numRegs(numRegs)) i_datapathAsserts (.*);

//--- datapathChecker.sv
`timescale 1ns/1ps

module datapathChecker #(
    parameter int numRegs = 16
) (
    input  logic               Clock,
    input  logic               rstN,
    input  logic [numRegs-1:0] regEnable,
    input  logic [numRegs-1:0] regOut,
    input  logic               pcOut, zLowOut, zHighOut, hiOut, loOut, mdrOut,
    input  logic               marEnable, mdrEnable, irEnable, yEnable,
    input  logic               zEnable, pcEnable, hiEnable, loEnable,
    input  logic               incPc,
    input  logic               read,
    input  cpuPkg::opcode_t    opcode,
    input  cpuPkg::word_t      mdatain,
    input  cpuPkg::word_t      bus,
    input  cpuPkg::word_t      marValue,
    input  cpuPkg::word_t      irValue,
    output int                 checkCount,
    output int                 errorCount
);
    import cpuPkg::*;

    word_t  regModel [numRegs];
    word_t  pcModel, irModel, hiModel, loModel, mdrModel, marModel, yModel;
    dword_t zModel;
    word_t  busNow;
    int     checks = 0;
    int     errors = 0;

    assign checkCount = checks;
    assign errorCount = errors;

    // expected Z contents for one operation on Y (a) and the bus (b)
    function automatic dword_t aluRef(opcode_t op, word_t a, word_t b);
        int             n;
        logic [63:0]    prod;
        n = int'(b[4:0]);
        prod = 64'($signed(a)) * 64'($signed(b));
        case (op)
            opAdd:   return {32'h0, a + b};
            opSub:   return {32'h0, a - b};
            opAnd:   return {32'h0, a & b};
            opOr:    return {32'h0, a | b};
            opShr:   return {32'h0, a >> n};
            opShra:  return {32'h0, word_t'($signed(a) >>> n)};
            opShl:   return {32'h0, a << n};
            opRor:   return {32'h0, (n == 0) ? a : ((a >> n) | (a << (32 - n)))};
            opRol:   return {32'h0, (n == 0) ? a : ((a << n) | (a >> (32 - n)))};
            opMul:   return prod;
            opDiv: begin
                if (b == 32'h0) begin
                    return {a, 32'hffff_ffff}; // remainder keeps the dividend
                end
                return {word_t'($signed(a) % $signed(b)), word_t'($signed(a) / $signed(b))};
            end
            opNeg:   return {32'h0, 32'h0 - b};
            opNot:   return {32'h0, ~b};
            default: return 64'h0;
        endcase
    endfunction

    function automatic word_t busModel();
        word_t v;
        v = '0;
        for (int i = 0; i < numRegs; i++) begin
            if (regOut[i]) v = regModel[i];
        end
        if (pcOut) v = pcModel;
        if (zLowOut) v = zModel[31:0];
        if (zHighOut) v = zModel[63:32];
        if (hiOut) v = hiModel;
        if (loOut) v = loModel;
        if (mdrOut) v = mdrModel;
        return v;
    endfunction

    task automatic compareWord(string name, word_t expected, word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s expected %08h, actual %08h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    always @(negedge Clock) begin
        compareWord("bus", busModel(), bus);
        compareWord("marValue", marModel, marValue);
        compareWord("irValue", irModel, irValue);
    end

    always @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) regModel[i] = '0;
            {pcModel, irModel, hiModel, loModel, mdrModel, marModel, yModel} = '0;
            zModel = '0;
        end else begin
            busNow = busModel();
            if (zEnable) zModel = aluRef(opcode, yModel, busNow); // uses Y before its load
            if (yEnable) yModel = busNow;
            for (int i = 0; i < numRegs; i++) begin
                if (regEnable[i]) regModel[i] = busNow;
            end
            if (pcEnable) pcModel = incPc ? pcModel + 32'd1 : busNow;
            if (irEnable) irModel = busNow;
            if (hiEnable) hiModel = busNow;
            if (loEnable) loModel = busNow;
            if (mdrEnable) mdrModel = read ? mdatain : busNow;
            if (marEnable) marModel = busNow;
        end
    end

endmodule

//--- datapathTb.sv
`timescale 1ns/1ps

module datapathTb;
    import cpuPkg::*;

    localparam int numRegs    = 16;
    localparam int cycleLimit = 2000; // sequence runs a little over 500 cycles

    logic               Clock = 1'b0;
    logic               rstN;
    logic [numRegs-1:0] regEnable;
    logic [numRegs-1:0] regOut;
    logic               pcOut, zLowOut, zHighOut, hiOut, loOut, mdrOut;
    logic               marEnable, mdrEnable, irEnable, yEnable;
    logic               zEnable, pcEnable, hiEnable, loEnable;
    logic               incPc;
    logic               read;
    opcode_t            opcode;
    word_t              mdatain;
    word_t              bus;
    word_t              marValue;
    word_t              irValue;
    int                 checkCount;
    int                 errorCount;
    int                 cycleCount = 0;
    integer             seed;
    opcode_t            opList [13];

    datapath #(.numRegs(numRegs)) i_dut (.*);

    datapathChecker #(.numRegs(numRegs)) i_checker (.*);

    always #5 Clock = ~Clock;

    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount == cycleLimit) begin
            $display("timeout: sequence still running after %0d cycles", cycleLimit);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic clearStrobes();
        {regEnable, regOut} = '0;
        {pcOut, zLowOut, zHighOut, hiOut, loOut, mdrOut} = '0;
        {marEnable, mdrEnable, irEnable, yEnable, zEnable, pcEnable, hiEnable, loEnable} = '0;
        {incPc, read} = '0;
        opcode  = '0;
        mdatain = '0;
    endtask

    task automatic nextCycle();
        @(posedge Clock);
        #1;
        clearStrobes();
    endtask

    task automatic loadReg(int idx, word_t value);
        nextCycle();
        mdatain   = value;
        read      = 1'b1;
        mdrEnable = 1'b1;
        nextCycle();
        mdrOut         = 1'b1;
        regEnable[idx] = 1'b1;
    endtask

    task automatic readReg(int idx);
        nextCycle();
        regOut[idx] = 1'b1;
    endtask

    task automatic showSource(int src); // 0 pc, 1 hi, 2 lo, 3 mdr, 4 z low, 5 z high
        nextCycle();
        case (src)
            0:       pcOut    = 1'b1;
            1:       hiOut    = 1'b1;
            2:       loOut    = 1'b1;
            3:       mdrOut   = 1'b1;
            4:       zLowOut  = 1'b1;
            default: zHighOut = 1'b1;
        endcase
    endtask

    task automatic aluOp(opcode_t op, int ra, int rb);
        nextCycle();
        regOut[ra] = 1'b1;
        yEnable    = 1'b1;
        nextCycle();
        regOut[rb] = 1'b1;
        opcode     = op;
        zEnable    = 1'b1;
        nextCycle();
        zLowOut  = 1'b1;
        loEnable = 1'b1;
        nextCycle();
        zHighOut = 1'b1;
        hiEnable = 1'b1;
    endtask

    task automatic runAluCase(opcode_t op, word_t a, word_t b);
        loadReg(1, a);
        loadReg(2, b);
        aluOp(op, 1, 2);
        showSource(2);
        showSource(1);
    endtask

    task automatic fetchStep(); // T0, PC to MAR and PC+1 in the same cycle
        nextCycle();
        pcOut     = 1'b1;
        marEnable = 1'b1;
        pcEnable  = 1'b1;
        incPc     = 1'b1;
    endtask

    task automatic memToSpecial(word_t value, bit toIr);
        nextCycle();
        mdatain   = value;
        read      = 1'b1;
        mdrEnable = 1'b1;
        nextCycle();
        mdrOut = 1'b1;
        if (toIr) irEnable = 1'b1;
        else pcEnable = 1'b1;
    endtask

    initial begin
        seed   = 32'hf6ab;
        opList = '{opAdd, opSub, opAnd, opOr, opShr, opShra, opShl, opRor, opRol,
                   opMul, opDiv, opNeg, opNot};
        rstN = 1'b0;
        clearStrobes();
        repeat (4) @(posedge Clock);
        #1;
        rstN = 1'b1;

        for (int i = 0; i < numRegs; i++) readReg(i);
        for (int s = 0; s < 6; s++) showSource(s);

        for (int i = 0; i < numRegs; i++) loadReg(i, $random(seed));
        for (int i = 0; i < numRegs; i++) readReg(i);
        loadReg(5, $random(seed)); // neighbours must keep their words
        for (int i = 0; i < numRegs; i++) readReg(i);

        for (int round = 0; round < 3; round++) begin
            for (int k = 0; k < 13; k++) runAluCase(opList[k], $random(seed), $random(seed));
        end
        runAluCase(opMul, 32'hffff_fff0, 32'h0000_0007);
        runAluCase(opDiv, 32'hffff_ff9c, 32'h0000_0007); // negative dividend
        runAluCase(opDiv, $random(seed), 32'h0);

        memToSpecial($random(seed), 1'b0);
        fetchStep();
        showSource(0);
        memToSpecial($random(seed), 1'b1);
        nextCycle();
        @(negedge Clock);
        #1;

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- datapath.f
cpuPkg.sv
registerFile.sv
specialRegs.sv
memPort.sv
aluUnit.sv
busMux.sv
datapath.sv
datapath_asserts.sv
datapathChecker.sv
datapathTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f datapath.f --top-module datapathTb -o simDatapath
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/simDatapath)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
